// File: laser.f
design/laser_pkg.sv
design/laser_ctrl.sv
design/scan_counter.sv
design/point_store.sv
design/cover_unit.sv
design/best_tracker.sv
design/laser_top.sv
tb/laser_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := laser_tb
FILELIST := laser.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb/laser_tb.sv
`timescale 1ns/1ps

module laser_tb;

    localparam int N_POINTS   = 40;
    localparam int GRID       = 16;
    localparam int R_SQ       = 16;
    localparam int CLK_PERIOD = 4;
    localparam int RUNS       = 5;
    localparam int RUN_CYCLES = 1200;
    localparam int DONE_LIMIT = 2 * RUN_CYCLES;
    // Five runs of up to 1200 cycles, with a margin of two
    localparam int WATCHDOG_NS = RUNS * RUN_CYCLES * CLK_PERIOD * 2;

    logic       CLK = 1'b0;
    logic       RST;
    logic [3:0] X;
    logic [3:0] Y;
    logic       valid;
    logic [3:0] C1X;
    logic [3:0] C1Y;
    logic       DONE;

    logic [3:0] px [N_POINTS];
    logic [3:0] py [N_POINTS];

    laser_top i_dut (
        .CLK   (CLK),
        .RST   (RST),
        .X     (X),
        .Y     (Y),
        .valid (valid),
        .C1X   (C1X),
        .C1Y   (C1Y),
        .DONE  (DONE)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, DONE never arrived", WATCHDOG_NS);
        $display("Checks failed");
        $fatal(1, "Run stopped by watchdog");
    end

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s: expected %0d, got %0d", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // One point per valid strobe, optional idle cycles in between
    task automatic load_points(input bit with_gaps);
        int gap;
        for (int i = 0; i < N_POINTS; i++) begin
            if (with_gaps) begin
                gap = int'($urandom % 4);
                repeat (gap) begin
                    @(posedge CLK);
                    valid <= 1'b0;
                end
            end
            @(posedge CLK);
            valid <= 1'b1;
            X     <= px[i];
            Y     <= py[i];
        end
        @(posedge CLK);
        valid <= 1'b0;
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while (!DONE) begin
            if (cycles == DONE_LIMIT) begin
                $display("%s: DONE did not arrive within %0d cycles", name, DONE_LIMIT);
                $display("Checks failed");
                $fatal(1, "Run stopped waiting for DONE");
            end
            cycles++;
            @(negedge CLK);
        end
    endtask

    // Scan order y outer, x inner; ties go to the later center
    task automatic model_best(output int best_x, output int best_y, output int best_cnt);
        int cnt;
        int dx;
        int dy;
        best_cnt = -1;
        best_x   = 0;
        best_y   = 0;
        for (int cy = 0; cy < GRID; cy++) begin
            for (int cx = 0; cx < GRID; cx++) begin
                cnt = 0;
                for (int i = 0; i < N_POINTS; i++) begin
                    dx = int'(px[i]) - cx;
                    dy = int'(py[i]) - cy;
                    if (dx * dx + dy * dy <= R_SQ) begin
                        cnt++;
                    end
                end
                if (cnt >= best_cnt) begin
                    best_cnt = cnt;
                    best_x   = cx;
                    best_y   = cy;
                end
            end
        end
    endtask

    task automatic run_and_check(input string name, input bit with_gaps,
                                 output int best_cnt);
        int ex;
        int ey;
        load_points(with_gaps);
        model_best(ex, ey, best_cnt);
        wait_done(name);
        check({name, " C1X"}, ex, int'(C1X));
        check({name, " C1Y"}, ey, int'(C1Y));
        // DONE must drop after a single cycle
        @(negedge CLK);
        check({name, " DONE width"}, 0, int'(DONE));
    endtask

    task automatic test_reset();
        @(negedge CLK);
        check("reset DONE", 0, int'(DONE));
        check("reset C1X", 0, int'(C1X));
        check("reset C1Y", 0, int'(C1Y));
    endtask

    task automatic test_cluster();
        int cnt;
        for (int i = 0; i < N_POINTS; i++) begin
            if (i < 30) begin
                px[i] = 4'(4 + i % 5);
                py[i] = 4'(7 + (i / 5) % 5);
            end else begin
                // Far corners
                px[i] = (i % 2 == 1) ? 4'd15 : 4'd0;
                py[i] = ((i / 2) % 2 == 1) ? 4'd15 : 4'd0;
            end
        end
        run_and_check("cluster", 1'b0, cnt);
    endtask

    task automatic test_random();
        int cnt;
        for (int i = 0; i < N_POINTS; i++) begin
            px[i] = 4'($urandom % 16);
            py[i] = 4'($urandom % 16);
        end
        run_and_check("random", 1'b1, cnt);
    endtask

    task automatic test_ties();
        int cnt;
        for (int i = 0; i < N_POINTS; i++) begin
            px[i] = 4'd0;
            py[i] = 4'd0;
        end
        run_and_check("ties", 1'b0, cnt);
        check("ties max count", 40, cnt);
        // Last covering center in scan order
        check("ties C1X", 0, int'(C1X));
        check("ties C1Y", 4, int'(C1Y));
    endtask

    task automatic test_independent();
        int cnt;
        for (int i = 0; i < N_POINTS; i++) begin
            px[i] = 4'(12 + i % 3);
            py[i] = 4'(12 + (i / 3) % 3);
        end
        run_and_check("dense run", 1'b0, cnt);
        for (int i = 0; i < N_POINTS; i++) begin
            px[i] = 4'((i * 3) % 8);
            py[i] = 4'((i * 5) % 8);
        end
        run_and_check("sparse run", 1'b1, cnt);
    endtask

    initial begin
        void'($urandom(86));
        RST   = 1'b1;
        valid = 1'b0;
        X     = '0;
        Y     = '0;
        repeat (4) @(posedge CLK);
        RST <= 1'b0;
        test_reset();
        test_cluster();
        test_random();
        test_ties();
        test_independent();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: design/laser_top.sv
`timescale 1ns/1ps

module laser_top (
    input  logic               CLK,
    input  logic               RST,
    input  laser_pkg::coord_t  X,
    input  laser_pkg::coord_t  Y,
    input  logic               valid,
    output laser_pkg::coord_t  C1X,
    output laser_pkg::coord_t  C1Y,
    output logic               DONE
);

    localparam int N_POINTS = 40;
    localparam int LANES    = 10;

    laser_pkg::ctrl_t              ctrl;
    laser_pkg::scan_pos_t          pos;
    logic                          center_last;
    laser_pkg::point_t             in_point;
    laser_pkg::point_t [LANES-1:0] lanes;
    laser_pkg::count_t             hits;

    always_comb begin
        in_point.x = X;
        in_point.y = Y;
    end

    laser_ctrl u_ctrl (
        .CLK         (CLK),
        .RST         (RST),
        .valid       (valid),
        .load_full   (pos.load_full),
        .group_last  (pos.group_last),
        .center_last (center_last),
        .ctrl        (ctrl),
        .DONE        (DONE)
    );

    scan_counter #(
        .N_POINTS (N_POINTS),
        .LANES    (LANES)
    ) u_counter (
        .CLK         (CLK),
        .RST         (RST),
        .ctrl        (ctrl),
        .pos         (pos),
        .center_last (center_last)
    );

    point_store #(
        .N_POINTS (N_POINTS),
        .LANES    (LANES)
    ) u_store (
        .CLK      (CLK),
        .RST      (RST),
        .wr       (ctrl.point_wr),
        .wr_addr  (pos.wr_addr),
        .wr_point (in_point),
        .group    (pos.group),
        .lanes    (lanes)
    );

    cover_unit #(
        .LANES (LANES)
    ) u_cover (
        .center (pos.center),
        .lanes  (lanes),
        .hits   (hits)
    );

    best_tracker u_best (
        .CLK        (CLK),
        .RST        (RST),
        .ctrl       (ctrl),
        .group_last (pos.group_last),
        .center     (pos.center),
        .hits       (hits),
        .C1X        (C1X),
        .C1Y        (C1Y)
    );

endmodule

// File: design/best_tracker.sv
`timescale 1ns/1ps

module best_tracker (
    input  logic               CLK,
    input  logic               RST,
    input  laser_pkg::ctrl_t   ctrl,
    input  logic               group_last,
    input  laser_pkg::point_t  center,
    input  laser_pkg::count_t  hits,
    output laser_pkg::coord_t  C1X,
    output laser_pkg::coord_t  C1Y
);

    laser_pkg::count_t acc;
    laser_pkg::count_t best;
    laser_pkg::count_t total;

    // Candidate total including the group in flight
    assign total = acc + hits;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            acc <= '0;
        end else if (ctrl.scan_clr) begin
            acc <= '0;
        end else if (ctrl.scan_en) begin
            acc <= group_last ? '0 : total;
        end
    end

    // Greater or equal, so the later center wins a tie
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            best <= '0;
        end else if (ctrl.scan_clr) begin
            best <= '0;
        end else if (ctrl.scan_en && group_last && (total >= best)) begin
            best <= total;
        end
    end

    // Result holds through IDLE and READ until the next scan
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            C1X <= '0;
            C1Y <= '0;
        end else if (ctrl.scan_en && group_last && (total >= best)) begin
            C1X <= center.x;
            C1Y <= center.y;
        end
    end

endmodule

// File: design/cover_unit.sv
`timescale 1ns/1ps

module cover_unit #(
    parameter int LANES = 10
) (
    input  laser_pkg::point_t             center,
    input  laser_pkg::point_t [LANES-1:0] lanes,
    output laser_pkg::count_t             hits
);

    logic [LANES-1:0] in_disk;

    // Per-lane disk test, dx*dx + dy*dy against the squared radius
    always_comb begin
        logic [3:0] dx;
        logic [3:0] dy;
        logic [8:0] dist_sq;
        for (int i = 0; i < LANES; i++) begin
            if (lanes[i].x > center.x) begin
                dx = lanes[i].x - center.x;
            end else begin
                dx = center.x - lanes[i].x;
            end
            if (lanes[i].y > center.y) begin
                dy = lanes[i].y - center.y;
            end else begin
                dy = center.y - lanes[i].y;
            end
            dist_sq    = 9'(dx) * 9'(dx) + 9'(dy) * 9'(dy);
            in_disk[i] = (dist_sq <= 9'(laser_pkg::RADIUS_SQ));
        end
    end

    always_comb begin
        laser_pkg::count_t sum;
        sum = '0;
        for (int i = 0; i < LANES; i++) begin
            sum = sum + laser_pkg::count_t'(in_disk[i]);
        end
        hits = sum;
    end

endmodule

// File: design/point_store.sv
`timescale 1ns/1ps

module point_store #(
    parameter int N_POINTS = 40,
    parameter int LANES    = 10
) (
    input  logic                          CLK,
    input  logic                          RST,
    input  logic                          wr,
    input  logic [5:0]                    wr_addr,
    input  laser_pkg::point_t             wr_point,
    input  logic [1:0]                    group,
    output laser_pkg::point_t [LANES-1:0] lanes
);

    laser_pkg::point_t mem [N_POINTS];

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            for (int i = 0; i < N_POINTS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr && (int'(wr_addr) < N_POINTS)) begin
            mem[wr_addr] <= wr_point;
        end
    end

    // Group g covers entries g*LANES up to g*LANES+LANES-1
    always_comb begin
        int base;
        base = int'(group) * LANES;
        for (int i = 0; i < LANES; i++) begin
            if (base + i < N_POINTS) begin
                lanes[i] = mem[base + i];
            end else begin
                lanes[i] = '0;
            end
        end
    end

endmodule

// File: design/scan_counter.sv
`timescale 1ns/1ps

module scan_counter #(
    parameter int N_POINTS = 40,
    parameter int LANES    = 10
) (
    input  logic                  CLK,
    input  logic                  RST,
    input  laser_pkg::ctrl_t      ctrl,
    output laser_pkg::scan_pos_t  pos,
    output logic                  center_last
);

    localparam int GROUPS = N_POINTS / LANES;

    logic [5:0]        wr_addr;
    logic [1:0]        group;
    laser_pkg::point_t center;
    logic              load_full;
    logic              group_last;

    assign load_full   = (wr_addr == 6'(N_POINTS));
    assign group_last  = (group == 2'(GROUPS - 1));
    assign center_last = (center.x == 4'd15) && (center.y == 4'd15);

    // Load address, wraps once the set is complete
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            wr_addr <= '0;
        end else if (ctrl.scan_clr || load_full) begin
            wr_addr <= '0;
        end else if (ctrl.point_wr) begin
            wr_addr <= wr_addr + 6'd1;
        end
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            group <= '0;
        end else if (ctrl.scan_clr) begin
            group <= '0;
        end else if (ctrl.scan_en) begin
            group <= group_last ? 2'd0 : group + 2'd1;
        end
    end

    // x runs fastest, y is the outer loop
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            center <= '0;
        end else if (ctrl.scan_clr) begin
            center <= '0;
        end else if (ctrl.scan_en && group_last) begin
            center.x <= center.x + 4'd1;
            if (center.x == 4'd15) begin
                center.y <= center.y + 4'd1;
            end
        end
    end

    always_comb begin
        pos.wr_addr    = wr_addr;
        pos.load_full  = load_full;
        pos.group      = group;
        pos.group_last = group_last;
        pos.center     = center;
    end

endmodule

// File: design/laser_ctrl.sv
`timescale 1ns/1ps

module laser_ctrl (
    input  logic              CLK,
    input  logic              RST,
    input  logic              valid,
    input  logic              load_full,
    input  logic              group_last,
    input  logic              center_last,
    output laser_pkg::ctrl_t  ctrl,
    output logic              DONE
);

    laser_pkg::state_t state;
    laser_pkg::state_t state_nxt;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state <= laser_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            laser_pkg::IDLE: begin
                state_nxt = laser_pkg::READ;
            end
            laser_pkg::READ: begin
                if (load_full) begin
                    state_nxt = laser_pkg::SCAN;
                end
            end
            laser_pkg::SCAN: begin
                // Last group of the last center closes the scan
                if (group_last && center_last) begin
                    state_nxt = laser_pkg::FINISH;
                end
            end
            default: begin
                state_nxt = laser_pkg::IDLE;
            end
        endcase
    end

    always_comb begin
        ctrl.point_wr = (state == laser_pkg::READ) && valid;
        ctrl.scan_en  = (state == laser_pkg::SCAN);
        ctrl.scan_clr = (state == laser_pkg::IDLE);
    end

    // One cycle pulse after FINISH
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            DONE <= 1'b0;
        end else begin
            DONE <= (state == laser_pkg::FINISH);
        end
    end

endmodule

// File: design/laser_pkg.sv
package laser_pkg;

    // Grid coordinate, 0 to 15 on either axis
    typedef logic [3:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // Hit count, wide enough for the full point set
    typedef logic [5:0] count_t;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        READ   = 2'd1,
        SCAN   = 2'd2,
        FINISH = 2'd3
    } state_t;

    // Controller strobes
    typedef struct packed {
        logic point_wr;
        logic scan_en;
        logic scan_clr;
    } ctrl_t;

    // Counter state shared by the store, the tracker and the FSM
    typedef struct packed {
        logic [5:0] wr_addr;
        logic       load_full;
        logic [1:0] group;
        logic       group_last;
        point_t     center;
    } scan_pos_t;

    // Squared spot radius
    localparam int RADIUS_SQ = 16;

endpackage
